// File: verilog/ldpc_code_pkg.sv
`default_nettype none

package ldpc_code_pkg;

	//////////////////////////////////////////////////
	// code structure
	//////////////////////////////////////////////////

	// slots per check row, one rom word each
	localparam int max_degree = 7;
	// cycles per row, fetch through last write
	localparam int row_cycles = 20;

	// address spaces of the external memories
	typedef logic [13:0] sum_addr_t;
	typedef logic [14:0] vc_addr_t;
	typedef logic [6:0]  rom_addr_t;
	typedef logic [2:0]  slot_t;

	// one circulant of a block row
	// valid entries sit in the low slots
	typedef struct packed {
		logic       valid;
		// column block start plus shift
		sum_addr_t  base;
		logic [8:0] shift;
	} rom_entry_t;

endpackage

`default_nettype wire

// File: verilog/ldpc_msg_pkg.sv
`default_nettype none

package ldpc_msg_pkg;

	//////////////////////////////////////////////////
	// message arithmetic
	//////////////////////////////////////////////////

	typedef logic signed [9:0] app_t;
	typedef logic signed [7:0] vc_t;
	typedef logic [7:0]        mag_t;

	// symmetric saturation, -512 never used
	localparam int app_max = 511;
	// magnitude cap for min search
	localparam int mag_max = 127;

	// per slot extrinsic result
	typedef struct packed {
		logic                 strobe;
		ldpc_code_pkg::slot_t slot;
		app_t                 rho;
		mag_t                 mag;
		logic                 sign;
	} ext_t;

	// what the write phase needs of a row
	typedef struct packed {
		mag_t                 min;
		mag_t                 sec_min;
		ldpc_code_pkg::slot_t min_idx;
		logic                 parity;
		logic [6:0]           signs;
	} row_summary_t;

	typedef struct packed {
		logic                     strobe;
		ldpc_code_pkg::sum_addr_t addr;
		app_t                     data;
	} app_wr_t;

	typedef struct packed {
		logic                    strobe;
		ldpc_code_pkg::vc_addr_t addr;
		vc_t                     data;
	} vc_wr_t;

	// 11 bit sum clipped to +-511
	function automatic app_t sat_app(input logic signed [10:0] v);
		if (v > app_max)
			return app_t'(app_max);
		if (v < -app_max)
			return app_t'(-app_max);
		return app_t'(v);
	endfunction

endpackage

`default_nettype wire

// File: verilog/row_store.sv
`timescale 1ns/1ps
`default_nettype none

module row_store #(
	parameter type payload_t = logic [7:0]
) (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       wr_en,
	input  wire ldpc_code_pkg::slot_t wr_idx,
	input  wire payload_t             wr_data,
	input  wire ldpc_code_pkg::slot_t rd_idx,
	output payload_t                  rd_data
);

	// one entry per slot of the current row
	payload_t entries [ldpc_code_pkg::max_degree];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < ldpc_code_pkg::max_degree; i++)
				entries[i] <= '0;
		end else if (wr_en) begin
			entries[wr_idx] <= wr_data;
		end
	end

	// async read, same cycle as index
	assign rd_data = entries[rd_idx];

endmodule

`default_nettype wire

// File: verilog/cnp_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cnp_sequencer #(
	parameter int circ_size  = 360,
	parameter int block_rows = 12
) (
	input  wire                             clk,
	input  wire                             rst,
	output ldpc_code_pkg::rom_addr_t        rom_addr,
	input  wire ldpc_code_pkg::rom_entry_t  rom_entry,
	output ldpc_code_pkg::sum_addr_t        app_rd_addr,
	output ldpc_code_pkg::vc_addr_t         vc_rd_addr,
	output logic                            rd_slot_strobe,
	output ldpc_code_pkg::slot_t            rd_slot,
	output logic                            row_close,
	output logic                            wr_slot_strobe,
	output ldpc_code_pkg::slot_t            wr_slot,
	output ldpc_code_pkg::sum_addr_t        wr_sum_addr,
	output ldpc_code_pkg::vc_addr_t         wr_vc_addr,
	output logic                            finish
);

	localparam int ib_w  = (circ_size > 1) ? $clog2(circ_size) : 1;
	localparam int blk_w = (block_rows > 1) ? $clog2(block_rows) : 1;
	// first cycle of each phase within a row
	localparam int rd_first  = 2;
	localparam int close_cyc = 11;
	localparam int wr_first  = 12;

	logic [4:0]                cyc;
	logic [ib_w-1:0]           ib;
	logic [blk_w-1:0]          blk;
	// row index times seven
	ldpc_code_pkg::vc_addr_t   row_base;
	logic                      row_end;
	logic                      last_row;
	logic                      fetch_phase;
	logic                      store_phase;
	logic                      rd_phase;
	logic                      wr_phase;
	ldpc_code_pkg::slot_t      fetch_slot;
	ldpc_code_pkg::slot_t      cur_slot;
	ldpc_code_pkg::rom_entry_t cur_entry;
	ldpc_code_pkg::sum_addr_t  cur_sum_addr;

	// circulant rotation of in-block index
	function automatic ldpc_code_pkg::sum_addr_t circ_addr(
		input ldpc_code_pkg::rom_entry_t entry,
		input logic [ib_w-1:0]           idx
	);
		ldpc_code_pkg::sum_addr_t ofs;
		ldpc_code_pkg::sum_addr_t room;
		ofs  = ldpc_code_pkg::sum_addr_t'(idx);
		room = ldpc_code_pkg::sum_addr_t'(circ_size) - ofs;
		if (ldpc_code_pkg::sum_addr_t'(entry.shift) < room)
			return entry.base + ofs;
		// wrapped past the end of the circulant
		return entry.base - room;
	endfunction

	//////////////////////////////////////////////////
	// row, block and in-block counters
	//////////////////////////////////////////////////

	assign row_end  = (cyc == 5'(ldpc_code_pkg::row_cycles - 1));
	assign last_row = (blk == blk_w'(block_rows - 1)) && (ib == ib_w'(circ_size - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cyc      <= '0;
			ib       <= '0;
			blk      <= '0;
			row_base <= '0;
			finish   <= 1'b0;
		end else if (!finish) begin
			if (row_end) begin
				cyc      <= '0;
				row_base <= row_base + ldpc_code_pkg::vc_addr_t'(ldpc_code_pkg::max_degree);
				if (last_row)
					finish <= 1'b1;
				if (ib == ib_w'(circ_size - 1)) begin
					ib  <= '0;
					blk <= blk + 1'b1;
				end else begin
					ib <= ib + 1'b1;
				end
			end else begin
				cyc <= cyc + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// rom fetch and entry store
	//////////////////////////////////////////////////

	// slot k fetched at c=k, stored at c=k+1
	assign fetch_phase = (cyc < ldpc_code_pkg::max_degree);
	assign store_phase = (cyc >= 1) && (cyc <= ldpc_code_pkg::max_degree);
	assign fetch_slot  = fetch_phase ? ldpc_code_pkg::slot_t'(cyc) : '0;
	assign rom_addr    = ldpc_code_pkg::rom_addr_t'(blk)
		* ldpc_code_pkg::rom_addr_t'(ldpc_code_pkg::max_degree)
		+ ldpc_code_pkg::rom_addr_t'(fetch_slot);

	row_store #(
		.payload_t(ldpc_code_pkg::rom_entry_t)
	) entry_store (
		.clk    (clk),
		.rst    (rst),
		.wr_en  (store_phase),
		.wr_idx (ldpc_code_pkg::slot_t'(cyc - 5'd1)),
		.wr_data(rom_entry),
		.rd_idx (cur_slot),
		.rd_data(cur_entry)
	);

	//////////////////////////////////////////////////
	// read and write slots
	//////////////////////////////////////////////////

	// one store read port, shared by both phases
	assign rd_phase = (cyc >= rd_first) && (cyc < rd_first + ldpc_code_pkg::max_degree);
	assign wr_phase = (cyc >= wr_first) && (cyc < wr_first + ldpc_code_pkg::max_degree);
	assign cur_slot = rd_phase ? ldpc_code_pkg::slot_t'(cyc - 5'(rd_first))
		: ldpc_code_pkg::slot_t'(cyc - 5'(wr_first));

	assign cur_sum_addr = circ_addr(cur_entry, ib);
	assign app_rd_addr  = cur_sum_addr;
	assign vc_rd_addr   = row_base + ldpc_code_pkg::vc_addr_t'(cur_slot);

	// read data lands one cycle after address
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_slot_strobe <= 1'b0;
			rd_slot        <= '0;
		end else begin
			rd_slot_strobe <= rd_phase && cur_entry.valid && !finish;
			rd_slot        <= cur_slot;
		end
	end

	// summary latch after last extrinsic at c=10
	assign row_close = (cyc == 5'(close_cyc)) && !finish;

	// update registers these, ports see them at c=13+k
	assign wr_slot_strobe = wr_phase && cur_entry.valid && !finish;
	assign wr_slot        = cur_slot;
	assign wr_sum_addr    = cur_sum_addr;
	assign wr_vc_addr     = row_base + ldpc_code_pkg::vc_addr_t'(cur_slot);

endmodule

`default_nettype wire

// File: verilog/extrinsic_calc.sv
`timescale 1ns/1ps
`default_nettype none

module extrinsic_calc (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       rd_slot_strobe,
	input  wire ldpc_code_pkg::slot_t rd_slot,
	input  wire ldpc_msg_pkg::app_t   app_rd_data,
	input  wire ldpc_msg_pkg::vc_t    vc_rd_data,
	output ldpc_msg_pkg::ext_t        ext
);

	logic signed [10:0] diff;
	ldpc_msg_pkg::mag_t mag_capped;

	// app minus old message, both widened to 11 bits
	assign diff = {app_rd_data[9], app_rd_data} - {{3{vc_rd_data[7]}}, vc_rd_data};

	// magnitude from the unsaturated difference
	always_comb begin
		if (diff > ldpc_msg_pkg::mag_max)
			mag_capped = ldpc_msg_pkg::mag_t'(ldpc_msg_pkg::mag_max);
		else if (diff < -ldpc_msg_pkg::mag_max)
			mag_capped = ldpc_msg_pkg::mag_t'(ldpc_msg_pkg::mag_max);
		else if (diff[10])
			mag_capped = ldpc_msg_pkg::mag_t'(-diff);
		else
			mag_capped = ldpc_msg_pkg::mag_t'(diff);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ext <= '0;
		end else begin
			ext.strobe <= rd_slot_strobe;
			ext.slot   <= rd_slot;
			// rho kept for the write phase
			ext.rho    <= ldpc_msg_pkg::sat_app(diff);
			ext.mag    <= mag_capped;
			ext.sign   <= diff[10];
		end
	end

endmodule

`default_nettype wire

// File: verilog/min_sum_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module min_sum_tracker (
	input  wire                              clk,
	input  wire                              rst,
	input  wire ldpc_msg_pkg::ext_t          ext,
	input  wire                              row_close,
	output ldpc_msg_pkg::row_summary_t       summary
);

	// running state of the row in flight
	ldpc_msg_pkg::row_summary_t acc;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else if (ext.strobe) begin
			if (ext.slot == '0) begin
				// first slot restarts the search
				acc.min     <= ext.mag;
				acc.sec_min <= ldpc_msg_pkg::mag_t'(ldpc_msg_pkg::mag_max);
				acc.min_idx <= '0;
				acc.parity  <= ext.sign;
				acc.signs   <= {6'b0, ext.sign};
			end else begin
				acc.parity          <= acc.parity ^ ext.sign;
				acc.signs[ext.slot] <= ext.sign;
				// tie goes to the later slot
				if (ext.mag <= acc.min) begin
					acc.sec_min <= acc.min;
					acc.min     <= ext.mag;
					acc.min_idx <= ext.slot;
				end else if (ext.mag < acc.sec_min) begin
					acc.sec_min <= ext.mag;
				end
			end
		end
	end

	// held through the write phase of the row
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			summary <= '0;
		else if (row_close)
			summary <= acc;
	end

endmodule

`default_nettype wire

// File: verilog/cnp_update.sv
`timescale 1ns/1ps
`default_nettype none

module cnp_update (
	input  wire                                clk,
	input  wire                                rst,
	input  wire ldpc_msg_pkg::ext_t            ext,
	input  wire ldpc_msg_pkg::row_summary_t    summary,
	input  wire                                wr_slot_strobe,
	input  wire ldpc_code_pkg::slot_t          wr_slot,
	input  wire ldpc_code_pkg::sum_addr_t      wr_sum_addr,
	input  wire ldpc_code_pkg::vc_addr_t       wr_vc_addr,
	output ldpc_msg_pkg::app_wr_t              app_wr,
	output ldpc_msg_pkg::vc_wr_t               vc_wr
);

	ldpc_msg_pkg::app_t rho;
	ldpc_msg_pkg::mag_t sel_mag;
	logic               neg;
	logic [9:0]         triple;
	logic signed [9:0]  scaled;
	ldpc_msg_pkg::vc_t  new_msg;
	ldpc_msg_pkg::app_t new_app;

	// rho per slot, filled during the read phase
	row_store #(
		.payload_t(ldpc_msg_pkg::app_t)
	) rho_store (
		.clk    (clk),
		.rst    (rst),
		.wr_en  (ext.strobe),
		.wr_idx (ext.slot),
		.wr_data(ext.rho),
		.rd_idx (wr_slot),
		.rd_data(rho)
	);

	// own slot excluded from its minimum
	assign sel_mag = (summary.min_idx == wr_slot) ? summary.sec_min : summary.min;
	// sign of the others, parity without own sign
	assign neg     = summary.parity ^ summary.signs[wr_slot];

	// 3/4 scaling, x3 then arithmetic shift by two
	assign triple  = {2'b0, sel_mag} + {1'b0, sel_mag, 1'b0};
	assign scaled  = neg ? -signed'(triple) : signed'(triple);
	assign new_msg = ldpc_msg_pkg::vc_t'(scaled >>> 2);
	assign new_app = ldpc_msg_pkg::sat_app({rho[9], rho} + {{3{new_msg[7]}}, new_msg});

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			app_wr <= '0;
			vc_wr  <= '0;
		end else begin
			app_wr.strobe <= wr_slot_strobe;
			app_wr.addr   <= wr_sum_addr;
			app_wr.data   <= new_app;
			vc_wr.strobe  <= wr_slot_strobe;
			vc_wr.addr    <= wr_vc_addr;
			vc_wr.data    <= new_msg;
		end
	end

endmodule

`default_nettype wire

// File: verilog/ldpc_layer_cnp.sv
`timescale 1ns/1ps
`default_nettype none

module ldpc_layer_cnp #(
	parameter int circ_size  = 360,
	parameter int block_rows = 12
) (
	input  wire                            clk,
	input  wire                            rst,
	output ldpc_code_pkg::rom_addr_t       rom_addr,
	input  wire ldpc_code_pkg::rom_entry_t rom_entry,
	output ldpc_code_pkg::sum_addr_t       app_rd_addr,
	input  wire ldpc_msg_pkg::app_t        app_rd_data,
	output ldpc_code_pkg::vc_addr_t        vc_rd_addr,
	input  wire ldpc_msg_pkg::vc_t         vc_rd_data,
	output ldpc_msg_pkg::app_wr_t          app_wr,
	output ldpc_msg_pkg::vc_wr_t           vc_wr,
	output logic                           finish
);

	// sequencer to datapath
	logic                       rd_slot_strobe;
	ldpc_code_pkg::slot_t       rd_slot;
	logic                       row_close;
	logic                       wr_slot_strobe;
	ldpc_code_pkg::slot_t       wr_slot;
	ldpc_code_pkg::sum_addr_t   wr_sum_addr;
	ldpc_code_pkg::vc_addr_t    wr_vc_addr;
	// datapath internals
	ldpc_msg_pkg::ext_t         ext;
	ldpc_msg_pkg::row_summary_t summary;

	cnp_sequencer #(
		.circ_size (circ_size),
		.block_rows(block_rows)
	) u_seq (
		.clk           (clk),
		.rst           (rst),
		.rom_addr      (rom_addr),
		.rom_entry     (rom_entry),
		.app_rd_addr   (app_rd_addr),
		.vc_rd_addr    (vc_rd_addr),
		.rd_slot_strobe(rd_slot_strobe),
		.rd_slot       (rd_slot),
		.row_close     (row_close),
		.wr_slot_strobe(wr_slot_strobe),
		.wr_slot       (wr_slot),
		.wr_sum_addr   (wr_sum_addr),
		.wr_vc_addr    (wr_vc_addr),
		.finish        (finish)
	);

	extrinsic_calc u_ext (
		.clk           (clk),
		.rst           (rst),
		.rd_slot_strobe(rd_slot_strobe),
		.rd_slot       (rd_slot),
		.app_rd_data   (app_rd_data),
		.vc_rd_data    (vc_rd_data),
		.ext           (ext)
	);

	min_sum_tracker u_min (
		.clk      (clk),
		.rst      (rst),
		.ext      (ext),
		.row_close(row_close),
		.summary  (summary)
	);

	cnp_update u_upd (
		.clk           (clk),
		.rst           (rst),
		.ext           (ext),
		.summary       (summary),
		.wr_slot_strobe(wr_slot_strobe),
		.wr_slot       (wr_slot),
		.wr_sum_addr   (wr_sum_addr),
		.wr_vc_addr    (wr_vc_addr),
		.app_wr        (app_wr),
		.vc_wr         (vc_wr)
	);

endmodule

`default_nettype wire

// File: verification/ldpc_layer_cnp_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module ldpc_layer_cnp_asserts (
	input wire                        clk,
	input wire                        rst,
	input wire ldpc_msg_pkg::app_wr_t app_wr,
	input wire ldpc_msg_pkg::vc_wr_t  vc_wr,
	input wire                        finish
);

	// number of failed properties
	int fail_count = 0;

	// both memories written in the same cycle
	strobe_pair: assert property (@(posedge clk) disable iff (rst)
		app_wr.strobe == vc_wr.strobe)
		else begin
			$error("app_wr and vc_wr strobes differ");
			fail_count++;
		end

	// finish is sticky until reset
	finish_sticky: assert property (@(posedge clk) disable iff (rst)
		finish |=> finish)
		else begin
			$error("finish dropped after rising");
			fail_count++;
		end

	// processor idle once done
	idle_after_finish: assert property (@(posedge clk) disable iff (rst)
		finish |-> !app_wr.strobe && !vc_wr.strobe)
		else begin
			$error("write strobe after finish");
			fail_count++;
		end

	// -512 is never produced by the saturation
	app_range: assert property (@(posedge clk) disable iff (rst)
		app_wr.strobe |-> (app_wr.data >= -10'sd511))
		else begin
			$error("written a-posteriori value out of range");
			fail_count++;
		end

endmodule

bind ldpc_layer_cnp ldpc_layer_cnp_asserts u_asserts (
	.clk   (clk),
	.rst   (rst),
	.app_wr(app_wr),
	.vc_wr (vc_wr),
	.finish(finish)
);

`default_nettype wire

// File: verification/tb_ldpc_layer_cnp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ldpc_layer_cnp;

	localparam int circ_size   = 4;
	localparam int block_rows  = 2;
	localparam int rows        = circ_size * block_rows;
	localparam int rom_words   = block_rows * 7;
	localparam int sum_words   = 28;
	localparam int vc_words    = rows * 7;
	// eight rows of 20 cycles, plus reset and slack
	localparam int cycle_limit = rows * ldpc_code_pkg::row_cycles + 240;

	logic                      clk;
	logic                      rst;
	ldpc_code_pkg::rom_addr_t  rom_addr;
	ldpc_code_pkg::rom_entry_t rom_entry;
	ldpc_code_pkg::sum_addr_t  app_rd_addr;
	ldpc_msg_pkg::app_t        app_rd_data;
	ldpc_code_pkg::vc_addr_t   vc_rd_addr;
	ldpc_msg_pkg::vc_t         vc_rd_data;
	ldpc_msg_pkg::app_wr_t     app_wr;
	ldpc_msg_pkg::vc_wr_t      vc_wr;
	logic                      finish;

	logic [23:0]               stim [0:69];
	ldpc_code_pkg::rom_entry_t rom_mem [rom_words];
	ldpc_msg_pkg::app_t        sum_mem [sum_words];
	ldpc_msg_pkg::vc_t         vc_mem [vc_words];
	ldpc_msg_pkg::app_t        model_sum [sum_words];
	ldpc_msg_pkg::vc_t         model_vc [vc_words];
	ldpc_msg_pkg::app_t        final_exp [sum_words];
	ldpc_msg_pkg::app_wr_t     exp_app_q [$];
	ldpc_msg_pkg::vc_wr_t      exp_vc_q [$];
	int                        row_writes [rows];
	int                        value_errors;
	int                        other_errors;
	int                        cycles;
	// addresses seen last cycle, data follows one cycle later
	int                        rom_q;
	int                        app_q;
	int                        vc_q;

	initial clk = 1'b0;
	always #4 clk = ~clk;

	ldpc_layer_cnp #(
		.circ_size (circ_size),
		.block_rows(block_rows)
	) dut (
		.clk        (clk),
		.rst        (rst),
		.rom_addr   (rom_addr),
		.rom_entry  (rom_entry),
		.app_rd_addr(app_rd_addr),
		.app_rd_data(app_rd_data),
		.vc_rd_addr (vc_rd_addr),
		.vc_rd_data (vc_rd_data),
		.app_wr     (app_wr),
		.vc_wr      (vc_wr),
		.finish     (finish)
	);

	function automatic int clip_app(input int v);
		if (v > 511)
			return 511;
		if (v < -511)
			return -511;
		return v;
	endfunction

	task automatic check_app_wr(input string name, input ldpc_msg_pkg::app_wr_t got,
		input ldpc_msg_pkg::app_wr_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_vc_wr(input string name, input ldpc_msg_pkg::vc_wr_t got,
		input ldpc_msg_pkg::vc_wr_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_app(input string name, input ldpc_msg_pkg::app_t got,
		input ldpc_msg_pkg::app_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic load_stimulus;
		$readmemh("verification/cnp_stimulus.txt", stim);
		if ($isunknown(stim[69])) begin
			$display("stimulus file missing or too short");
			other_errors++;
		end
		for (int i = 0; i < rom_words; i++)
			rom_mem[i] = stim[i];
		for (int i = 0; i < sum_words; i++) begin
			sum_mem[i]   = stim[14 + i][9:0];
			model_sum[i] = stim[14 + i][9:0];
			final_exp[i] = stim[42 + i][9:0];
		end
		for (int i = 0; i < vc_words; i++) begin
			vc_mem[i]   = '0;
			model_vc[i] = '0;
		end
	endtask

	// reference model, one row at a time over the model memories
	task automatic build_expected;
		ldpc_code_pkg::rom_entry_t e;
		ldpc_msg_pkg::app_wr_t     aw;
		ldpc_msg_pkg::vc_wr_t      vw;
		int                        addr [7];
		int                        rho [7];
		logic [6:0]                sgn;
		int row, degree, va, diff, mag, m1, m2, midx, par, sel, prod, msg;
		for (int blk = 0; blk < block_rows; blk++) begin
			for (int ib = 0; ib < circ_size; ib++) begin
				row    = blk * circ_size + ib;
				degree = 0;
				sgn    = '0;
				for (int s = 0; s < 7; s++) begin
					e = rom_mem[blk * 7 + s];
					if (e.valid && degree == s) begin
						degree = s + 1;
						// circulant wrap inside the column block
						if (int'(e.shift) < circ_size - ib)
							addr[s] = int'(e.base) + ib;
						else
							addr[s] = int'(e.base) + ib - circ_size;
						va     = row * 7 + s;
						diff   = int'(model_sum[addr[s]]) - int'(model_vc[va]);
						rho[s] = clip_app(diff);
						mag    = (diff < 0) ? -diff : diff;
						if (mag > 127)
							mag = 127;
						sgn[s] = (diff < 0);
						if (s == 0) begin
							m1   = mag;
							m2   = 127;
							midx = 0;
							par  = sgn[0];
						end else begin
							par = par ^ sgn[s];
							// ties move the minimum to the later slot
							if (mag <= m1) begin
								m2   = m1;
								m1   = mag;
								midx = s;
							end else if (mag < m2) begin
								m2 = mag;
							end
						end
					end
				end
				for (int s = 0; s < degree; s++) begin
					sel  = (s == midx) ? m2 : m1;
					prod = 3 * sel;
					if (par ^ sgn[s])
						prod = -prod;
					msg       = prod >>> 2;
					aw.strobe = 1'b1;
					aw.addr   = ldpc_code_pkg::sum_addr_t'(addr[s]);
					aw.data   = ldpc_msg_pkg::app_t'(clip_app(rho[s] + msg));
					vw.strobe = 1'b1;
					vw.addr   = ldpc_code_pkg::vc_addr_t'(row * 7 + s);
					vw.data   = ldpc_msg_pkg::vc_t'(msg);
					exp_app_q.push_back(aw);
					exp_vc_q.push_back(vw);
					model_sum[addr[s]]  = aw.data;
					model_vc[row * 7 + s] = vw.data;
				end
			end
		end
	endtask

	task automatic apply_write;
		ldpc_msg_pkg::app_wr_t ea;
		ldpc_msg_pkg::vc_wr_t  ev;
		if (exp_app_q.size() == 0) begin
			$display("write strobe with no write left to expect");
			other_errors++;
		end else begin
			ea = exp_app_q.pop_front();
			ev = exp_vc_q.pop_front();
			check_app_wr("app_wr", app_wr, ea);
			check_vc_wr("vc_wr", vc_wr, ev);
		end
		if (app_wr.addr < sum_words)
			sum_mem[app_wr.addr] = app_wr.data;
		if (vc_wr.addr < vc_words) begin
			vc_mem[vc_wr.addr] = vc_wr.data;
			row_writes[vc_wr.addr / 7]++;
		end
	endtask

	//////////////////////////////////////////////////
	// memory models and write monitor, falling edge
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		if (rst) begin
			if (app_wr.strobe || vc_wr.strobe || finish) begin
				$display("strobe or finish high during reset");
				other_errors++;
			end
		end else if (app_wr.strobe) begin
			apply_write();
		end else if (vc_wr.strobe) begin
			$display("message write without a-posteriori write");
			other_errors++;
		end
		rom_entry   = (rom_q < rom_words) ? rom_mem[rom_q] : '0;
		app_rd_data = (app_q < sum_words) ? sum_mem[app_q] : '0;
		vc_rd_data  = (vc_q < vc_words) ? vc_mem[vc_q] : '0;
		rom_q = int'(rom_addr);
		app_q = int'(app_rd_addr);
		vc_q  = int'(vc_rd_addr);
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout, finish not raised within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		rst          = 1'b1;
		rom_entry    = '0;
		app_rd_data  = '0;
		vc_rd_data   = '0;
		rom_q        = 0;
		app_q        = 0;
		vc_q         = 0;
		cycles       = 0;
		value_errors = 0;
		other_errors = 0;
		for (int r = 0; r < rows; r++)
			row_writes[r] = 0;
		load_stimulus();
		build_expected();
		// model against the file's final values
		for (int i = 0; i < sum_words; i++)
			check_app("model_sum", model_sum[i], final_exp[i]);
		repeat (8) @(negedge clk);
		rst = 1'b0;
		while (!finish)
			@(negedge clk);
		repeat (4) @(negedge clk);
		if (exp_app_q.size() != 0) begin
			$display("%0d expected writes never happened", exp_app_q.size());
			other_errors++;
		end
		// block row 0 has degree 5, block row 1 degree 7
		for (int r = 0; r < rows; r++) begin
			if (row_writes[r] != ((r < circ_size) ? 5 : 7)) begin
				$display("row %0d wrote %0d slots", r, row_writes[r]);
				other_errors++;
			end
		end
		for (int i = 0; i < sum_words; i++)
			check_app("sum_mem", sum_mem[i], final_exp[i]);
		$display("errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
			dut.u_asserts.fail_count);
		if (value_errors == 0 && other_errors == 0 && dut.u_asserts.fail_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
verilog/ldpc_code_pkg.sv
verilog/ldpc_msg_pkg.sv
verilog/row_store.sv
verilog/cnp_sequencer.sv
verilog/extrinsic_calc.sv
verilog/min_sum_tracker.sv
verilog/cnp_update.sv
verilog/ldpc_layer_cnp.sv
verification/ldpc_layer_cnp_asserts.sv
verification/tb_ldpc_layer_cnp.sv

// File: Bender.yml
package:
  name: ldpc_layer_cnp

sources:
  - verilog/ldpc_code_pkg.sv
  - verilog/ldpc_msg_pkg.sv
  - verilog/row_store.sv
  - verilog/cnp_sequencer.sv
  - verilog/extrinsic_calc.sv
  - verilog/min_sum_tracker.sv
  - verilog/cnp_update.sv
  - verilog/ldpc_layer_cnp.sv
  - target: test
    files:
      - verification/ldpc_layer_cnp_asserts.sv
      - verification/tb_ldpc_layer_cnp.sv

// File: verification/cnp_stimulus.txt
// lines 1-14: rom words {valid, base[13:0], shift[8:0]}, block 0 slots 0-6 then block 1
// lines 15-21: initial sum ram, 4 words per line; lines 22-28: expected final sum ram
800000
800A01
801402
801E03
802000
000000
000000
800603
800C02
801201
801800
802201
802C02
803603
064 1FF 028 3FD
007 3EC 1EA 032
03C 3FF 0C8 207
1E0 046 001 01E
3EC 3F6 050 005
002 021 03C 3C0
040 2D4 380 3A6
043 1FF 034 3FA
007 3F5 1F2 020
041 3FB 0A7 201
1E8 034 002 014
3F5 394 03E 005
002 006 03D 3F0
010 2D3 398 3A4
